//--- common/conv_addr_defines.svh
`ifndef CONV_ADDR_DEFINES_SVH
`define CONV_ADDR_DEFINES_SVH

// Buffer word geometry
`define CONV_PIX_ROW_LOG2 5
`define CONV_IFS_ROW_LOG2 1

// Buffer depths, log2 of words
`define CONV_IN_BUF_LOG2 12
`define CONV_SLAB_BUF_LOG2 13

// Rotating line buffers for a 3-row kernel
`define CONV_RING_ROWS 3

// Marker for an unused or invalid address
`define CONV_ADDR_NONE 16'hffff

`endif

//--- common/conv_addr_pkg.sv
`default_nettype none

package conv_addr_pkg;

  // Host command opcodes
  typedef enum logic [1:0] {
    OP_SET_SHAPE = 2'd0,
    OP_SET_BASE  = 2'd1,
    OP_SET_SLAB  = 2'd2,
    OP_FETCH     = 2'd3
  } conv_op_e;

  // Command port handshake
  typedef enum logic [1:0] {
    DEC_IDLE = 2'd0,
    DEC_ACK  = 2'd1,
    DEC_WAIT = 2'd2
  } dec_state_e;

  // Result port handshake
  typedef enum logic [1:0] {
    RES_IDLE = 2'd0,
    RES_REQ  = 2'd1,
    RES_DROP = 2'd2
  } res_state_e;

  typedef logic [15:0] addr_t;

  // Zero means no line buffer, 1 to 3 select one
  typedef logic [1:0] ring_idx_t;

  typedef logic [3:0] field_t;

endpackage

`default_nettype wire

//--- conv_addr/conv_addr_result.sv
`timescale 1ns/1ps
`default_nettype none

module conv_addr_result (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          fetch_go,
  input  wire                          valid,
  input  wire conv_addr_pkg::addr_t    row_idx,
  input  wire conv_addr_pkg::addr_t    buf_adr,
  input  wire conv_addr_pkg::ring_idx_t buf_idx,
  input  wire                          word_sel,
  input  wire conv_addr_pkg::addr_t    slab_adr,
  input  wire conv_addr_pkg::ring_idx_t slab_idx,
  input  wire conv_addr_pkg::addr_t    slab_wr_adr,
  input  wire conv_addr_pkg::ring_idx_t slab_wr_idx,
  input  wire                          res_ack,
  output logic                         res_req,
  output logic                         res_valid,
  output conv_addr_pkg::addr_t         res_row_idx,
  output conv_addr_pkg::addr_t         res_buf_adr,
  output conv_addr_pkg::ring_idx_t     res_buf_idx,
  output logic                         res_word_sel,
  output conv_addr_pkg::addr_t         res_slab_adr,
  output conv_addr_pkg::ring_idx_t     res_slab_idx,
  output conv_addr_pkg::addr_t         res_slab_wr_adr,
  output conv_addr_pkg::ring_idx_t     res_slab_wr_idx,
  output logic                         res_busy
);

  conv_addr_pkg::res_state_e state;

  // Busy from the fetch pulse until the consumer releases ack
  assign res_busy = fetch_go || (state != conv_addr_pkg::RES_IDLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= conv_addr_pkg::RES_IDLE;
      res_req <= 1'b0;
    end else begin
      case (state)
        conv_addr_pkg::RES_IDLE: begin
          if (fetch_go) begin
            state   <= conv_addr_pkg::RES_REQ;
            res_req <= 1'b1;
          end
        end
        conv_addr_pkg::RES_REQ: begin
          if (res_ack) begin
            state   <= conv_addr_pkg::RES_DROP;
            res_req <= 1'b0;
          end
        end
        conv_addr_pkg::RES_DROP: if (!res_ack) state <= conv_addr_pkg::RES_IDLE;
        default: state <= conv_addr_pkg::RES_IDLE;
      endcase
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (fetch_go) begin
      res_valid       <= valid;
      res_row_idx     <= row_idx;
      res_buf_adr     <= buf_adr;
      res_buf_idx     <= buf_idx;
      res_word_sel    <= word_sel;
      res_slab_adr    <= slab_adr;
      res_slab_idx    <= slab_idx;
      res_slab_wr_adr <= slab_wr_adr;
      res_slab_wr_idx <= slab_wr_idx;
    end
  end

  res_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
    res_req |=> !res_req || $stable({res_valid, res_row_idx, res_buf_adr, res_buf_idx,
                                     res_word_sel, res_slab_adr, res_slab_idx,
                                     res_slab_wr_adr, res_slab_wr_idx}));

endmodule

`default_nettype wire

//--- conv_addr/conv_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module conv_cmd_decode (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          cmd_req,
  input  wire conv_addr_pkg::conv_op_e cmd_op,
  input  wire conv_addr_pkg::addr_t    cmd_a,
  input  wire conv_addr_pkg::addr_t    cmd_b,
  input  wire conv_addr_pkg::addr_t    cmd_c,
  input  wire [1:0]                    cmd_krow,
  input  wire                          res_busy,
  output logic                         cmd_ack,
  output conv_addr_pkg::field_t        stride,
  output conv_addr_pkg::field_t        pad,
  output conv_addr_pkg::field_t        nif_log2,
  output conv_addr_pkg::field_t        ix_log2,
  output conv_addr_pkg::addr_t         iy,
  output conv_addr_pkg::addr_t         poy,
  output conv_addr_pkg::addr_t         row_base,
  output conv_addr_pkg::addr_t         row_start,
  output conv_addr_pkg::addr_t         if_start,
  output conv_addr_pkg::addr_t         slab_start,
  output conv_addr_pkg::field_t        slab_num,
  output conv_addr_pkg::addr_t         ky,
  output conv_addr_pkg::addr_t         iy_start,
  output logic [1:0]                   krow,
  output logic                         fetch_go
);

  conv_addr_pkg::dec_state_e state;
  logic                      is_fetch;
  logic                      accept;

  assign is_fetch = (cmd_op == conv_addr_pkg::OP_FETCH);

  // A fetch is only taken once the result stage has drained
  assign accept = ((state == conv_addr_pkg::DEC_IDLE) && cmd_req && !(is_fetch && res_busy))
               || ((state == conv_addr_pkg::DEC_WAIT) && !res_busy);

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= conv_addr_pkg::DEC_IDLE;
      cmd_ack  <= 1'b0;
      fetch_go <= 1'b0;
    end else begin
      fetch_go <= accept && is_fetch;
      if (accept) begin
        state   <= conv_addr_pkg::DEC_ACK;
        cmd_ack <= 1'b1;
      end else begin
        case (state)
          // Only a blocked fetch gets here
          conv_addr_pkg::DEC_IDLE: if (cmd_req) state <= conv_addr_pkg::DEC_WAIT;
          conv_addr_pkg::DEC_ACK: begin
            if (!cmd_req) begin
              state   <= conv_addr_pkg::DEC_IDLE;
              cmd_ack <= 1'b0;
            end
          end
          conv_addr_pkg::DEC_WAIT: state <= conv_addr_pkg::DEC_WAIT;
          default: state <= conv_addr_pkg::DEC_IDLE;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Configuration and fetch fields

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stride     <= '0;
      pad        <= '0;
      nif_log2   <= '0;
      ix_log2    <= '0;
      iy         <= '0;
      poy        <= '0;
      row_base   <= '0;
      row_start  <= '0;
      if_start   <= '0;
      slab_num   <= '0;
      slab_start <= '0;
      ky         <= '0;
      iy_start   <= '0;
      krow       <= '0;
    end else if (accept) begin
      case (cmd_op)
        conv_addr_pkg::OP_SET_SHAPE: begin
          stride   <= cmd_a[3:0];
          pad      <= cmd_a[7:4];
          nif_log2 <= cmd_a[11:8];
          ix_log2  <= cmd_a[15:12];
          iy       <= cmd_b;
          poy      <= cmd_c;
        end
        conv_addr_pkg::OP_SET_BASE: begin
          row_base  <= cmd_a;
          row_start <= cmd_b;
          if_start  <= cmd_c;
        end
        conv_addr_pkg::OP_SET_SLAB: begin
          slab_num   <= cmd_a[3:0];
          slab_start <= cmd_b;
        end
        default: begin
          ky       <= cmd_a;
          iy_start <= cmd_b;
          krow     <= cmd_krow;
        end
      endcase
    end
  end

  // Ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(cmd_ack) |-> $past(cmd_req));

  fetch_go_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    fetch_go |=> !fetch_go);

endmodule

`default_nettype wire

//--- conv_addr/conv_row_translate.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_addr_defines.svh"

module conv_row_translate (
  input  wire conv_addr_pkg::field_t   stride,
  input  wire conv_addr_pkg::field_t   pad,
  input  wire conv_addr_pkg::field_t   nif_log2,
  input  wire conv_addr_pkg::field_t   ix_log2,
  input  wire conv_addr_pkg::addr_t    iy,
  input  wire conv_addr_pkg::addr_t    poy,
  input  wire conv_addr_pkg::addr_t    row_base,
  input  wire conv_addr_pkg::addr_t    row_start,
  input  wire conv_addr_pkg::addr_t    if_start,
  input  wire conv_addr_pkg::addr_t    slab_start,
  input  wire conv_addr_pkg::field_t   slab_num,
  input  wire conv_addr_pkg::addr_t    ky,
  input  wire conv_addr_pkg::addr_t    iy_start,
  input  wire [1:0]                    krow,
  output logic                         valid,
  output conv_addr_pkg::addr_t         row_idx,
  output conv_addr_pkg::addr_t         buf_adr,
  output conv_addr_pkg::ring_idx_t     buf_idx,
  output logic                         word_sel,
  output conv_addr_pkg::addr_t         slab_adr,
  output conv_addr_pkg::ring_idx_t     slab_idx,
  output conv_addr_pkg::addr_t         slab_wr_adr,
  output conv_addr_pkg::ring_idx_t     slab_wr_idx
);

  localparam conv_addr_pkg::field_t PIX_LOG2 = conv_addr_pkg::field_t'(`CONV_PIX_ROW_LOG2);
  localparam conv_addr_pkg::field_t IFS_LOG2 = conv_addr_pkg::field_t'(`CONV_IFS_ROW_LOG2);
  localparam conv_addr_pkg::field_t IN_LOG2  = conv_addr_pkg::field_t'(`CONV_IN_BUF_LOG2);
  localparam conv_addr_pkg::field_t SLAB_LOG2 = conv_addr_pkg::field_t'(`CONV_SLAB_BUF_LOG2);
  localparam conv_addr_pkg::addr_t  RING_ROWS = conv_addr_pkg::addr_t'(`CONV_RING_ROWS);
  localparam conv_addr_pkg::addr_t  ADDR_NONE = `CONV_ADDR_NONE;

  conv_addr_pkg::addr_t     pad_w;
  conv_addr_pkg::addr_t     s_krow;
  conv_addr_pkg::addr_t     s_mult_3;
  conv_addr_pkg::addr_t     row_sum;
  conv_addr_pkg::addr_t     bias0;
  conv_addr_pkg::addr_t     bias;
  conv_addr_pkg::addr_t     bias_m1;
  conv_addr_pkg::addr_t     base;
  conv_addr_pkg::addr_t     base_s;
  conv_addr_pkg::addr_t     group;
  conv_addr_pkg::addr_t     row_in_buf;
  conv_addr_pkg::addr_t     if_start_m1;
  conv_addr_pkg::addr_t     in_mask;
  conv_addr_pkg::addr_t     slab_mask;
  conv_addr_pkg::addr_t     buf_adr_raw;
  conv_addr_pkg::addr_t     slab_rd_raw;
  conv_addr_pkg::addr_t     slab_wr_raw;
  conv_addr_pkg::field_t    in_if_shift;
  conv_addr_pkg::field_t    buf_shift;
  conv_addr_pkg::field_t    slab_shift;
  conv_addr_pkg::field_t    in_lim;
  conv_addr_pkg::field_t    slab_lim;
  conv_addr_pkg::ring_idx_t ring;
  logic                     wrap;
  logic                     stride_ok;
  logic                     slab_on;

  ////////////////////////////////////////////////////////////////////////////
  // Row index and validity

  assign pad_w    = {12'b0, pad};
  // stride * krow with krow in 0..3
  assign s_krow   = (krow[1] ? {11'b0, stride, 1'b0} : 16'd0)
                  + (krow[0] ? {12'b0, stride} : 16'd0);
  assign s_mult_3 = {11'b0, stride, 1'b0} + {12'b0, stride};
  assign row_sum  = ky + iy_start + s_krow;

  // Rows outside [pad+1, pad+iy] are padding or past the bottom edge
  assign valid = (poy >= 16'd3) && (row_sum >= pad_w + 16'd1) && (row_sum <= pad_w + iy);

  ////////////////////////////////////////////////////////////////////////////
  // Ring position

  assign bias0 = ky + 16'd1 + s_krow - pad_w;
  // Zero or negative bias belongs to the previous group of three
  assign wrap  = bias0[15] || (bias0 == 16'd0);
  assign bias  = wrap ? bias0 + s_mult_3 : bias0;
  assign base  = wrap ? row_base - 16'd1 : row_base;

  assign bias_m1 = bias - 16'd1;
  assign group   = bias_m1 / RING_ROWS;
  assign ring    = conv_addr_pkg::ring_idx_t'(bias_m1 % RING_ROWS) + 2'd1;

  // Only strides 1 and 2 map onto the ring
  assign stride_ok  = (stride == 4'd1) || (stride == 4'd2);
  assign base_s     = (stride == 4'd2) ? {base[14:0], 1'b0} : base;
  assign row_in_buf = stride_ok ? base_s + group : 16'd0;

  ////////////////////////////////////////////////////////////////////////////
  // Buffer and slab addresses

  assign in_if_shift = nif_log2 - IFS_LOG2;
  assign buf_shift   = in_if_shift + ix_log2 - PIX_LOG2;
  assign slab_shift  = nif_log2 + ix_log2 - PIX_LOG2;

  // Rows that fit in each buffer, as a wrap mask
  assign in_lim    = IN_LOG2 - buf_shift;
  assign slab_lim  = SLAB_LOG2 - slab_shift;
  assign in_mask   = ADDR_NONE >> (5'd16 - {1'b0, in_lim});
  assign slab_mask = ADDR_NONE >> (5'd16 - {1'b0, slab_lim});

  assign if_start_m1 = if_start - 16'd1;

  assign buf_adr_raw = ((row_in_buf & in_mask) << buf_shift)
                     + ((row_start << in_if_shift) >> PIX_LOG2)
                     + (if_start_m1 >> IFS_LOG2);

  assign slab_rd_raw = ((row_in_buf & slab_mask) << slab_shift)
                     + ((slab_start << nif_log2) >> PIX_LOG2)
                     + if_start_m1;

  // Write-back goes to the rows of the current output block
  assign slab_wr_raw = ((row_in_buf & slab_mask) << slab_shift)
                     + ((row_start << nif_log2) >> PIX_LOG2)
                     + if_start_m1;

  assign slab_on = valid && (slab_num != 4'd0);

  assign row_idx     = valid ? row_sum : ADDR_NONE;
  assign buf_adr     = valid ? buf_adr_raw : ADDR_NONE;
  assign buf_idx     = valid ? ring : 2'd0;
  assign word_sel    = if_start_m1[0];
  assign slab_adr    = slab_on ? slab_rd_raw : ADDR_NONE;
  assign slab_idx    = slab_on ? ring : 2'd0;
  assign slab_wr_adr = valid ? slab_wr_raw : ADDR_NONE;
  assign slab_wr_idx = valid ? ring : 2'd0;

  // A valid row must land on a positive bias once wrapped
  always_comb begin
    if (valid) begin
      bias_positive: assert final (!bias[15] && (bias != 16'd0));
    end
  end

endmodule

`default_nettype wire

//--- hdl/conv_addr_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_addr_top (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          cmd_req,
  input  wire conv_addr_pkg::conv_op_e cmd_op,
  input  wire conv_addr_pkg::addr_t    cmd_a,
  input  wire conv_addr_pkg::addr_t    cmd_b,
  input  wire conv_addr_pkg::addr_t    cmd_c,
  input  wire [1:0]                    cmd_krow,
  output logic                         cmd_ack,
  output logic                         res_req,
  output logic                         res_valid,
  output conv_addr_pkg::addr_t         res_row_idx,
  output conv_addr_pkg::addr_t         res_buf_adr,
  output conv_addr_pkg::ring_idx_t     res_buf_idx,
  output logic                         res_word_sel,
  output conv_addr_pkg::addr_t         res_slab_adr,
  output conv_addr_pkg::ring_idx_t     res_slab_idx,
  output conv_addr_pkg::addr_t         res_slab_wr_adr,
  output conv_addr_pkg::ring_idx_t     res_slab_wr_idx,
  input  wire                          res_ack
);

  // Held configuration
  conv_addr_pkg::field_t stride, pad, nif_log2, ix_log2, slab_num;
  conv_addr_pkg::addr_t  iy, poy, row_base, row_start, if_start, slab_start;

  // Current fetch
  conv_addr_pkg::addr_t  ky, iy_start;
  logic [1:0]            krow;
  logic                  fetch_go;
  logic                  res_busy;

  // Translation, valid while fetch_go is high
  logic                     valid, word_sel;
  conv_addr_pkg::addr_t     row_idx, buf_adr, slab_adr, slab_wr_adr;
  conv_addr_pkg::ring_idx_t buf_idx, slab_idx, slab_wr_idx;

  conv_cmd_decode decode_i (
    .clk, .arst_n, .cmd_req, .cmd_op, .cmd_a, .cmd_b, .cmd_c, .cmd_krow, .res_busy,
    .cmd_ack, .stride, .pad, .nif_log2, .ix_log2, .iy, .poy, .row_base, .row_start,
    .if_start, .slab_start, .slab_num, .ky, .iy_start, .krow, .fetch_go
  );

  conv_row_translate translate_i (
    .stride, .pad, .nif_log2, .ix_log2, .iy, .poy, .row_base, .row_start, .if_start,
    .slab_start, .slab_num, .ky, .iy_start, .krow,
    .valid, .row_idx, .buf_adr, .buf_idx, .word_sel, .slab_adr, .slab_idx,
    .slab_wr_adr, .slab_wr_idx
  );

  conv_addr_result result_i (
    .clk, .arst_n, .fetch_go,
    .valid, .row_idx, .buf_adr, .buf_idx, .word_sel, .slab_adr, .slab_idx,
    .slab_wr_adr, .slab_wr_idx, .res_ack,
    .res_req, .res_valid, .res_row_idx, .res_buf_adr, .res_buf_idx, .res_word_sel,
    .res_slab_adr, .res_slab_idx, .res_slab_wr_adr, .res_slab_wr_idx, .res_busy
  );

endmodule

`default_nettype wire

//--- project.f
+incdir+common
+incdir+tests
common/conv_addr_pkg.sv
conv_addr/conv_cmd_decode.sv
conv_addr/conv_row_translate.sv
conv_addr/conv_addr_result.sv
hdl/conv_addr_top.sv
tests/conv_addr_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
  --top-module conv_addr_tb -Mdir obj_dir -o conv_addr_sim || exit 1
out=$(./obj_dir/conv_addr_sim 2>&1)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

//--- tests/conv_addr_model.svh
`ifndef CONV_ADDR_MODEL_SVH
`define CONV_ADDR_MODEL_SVH

`include "conv_addr_defines.svh"

// One expected answer, in result port order
typedef struct packed {
  logic                     valid;
  conv_addr_pkg::addr_t     row_idx;
  conv_addr_pkg::addr_t     buf_adr;
  conv_addr_pkg::ring_idx_t buf_idx;
  logic                     word_sel;
  conv_addr_pkg::addr_t     slab_adr;
  conv_addr_pkg::ring_idx_t slab_idx;
  conv_addr_pkg::addr_t     slab_wr_adr;
  conv_addr_pkg::ring_idx_t slab_wr_idx;
} result_t;

// Configuration as last written by the host
conv_addr_pkg::field_t cfg_stride, cfg_pad, cfg_nif, cfg_ix, cfg_slab_num;
conv_addr_pkg::addr_t  cfg_iy, cfg_poy, cfg_base, cfg_row_start, cfg_if_start;
conv_addr_pkg::addr_t  cfg_slab_start;

function automatic result_t predict(input conv_addr_pkg::addr_t ky,
                                    input conv_addr_pkg::addr_t iy_start,
                                    input logic [1:0]           krow);
  result_t              r;
  conv_addr_pkg::addr_t step, pad16, row, bias, base, group, rib, ifm1;
  conv_addr_pkg::addr_t in_rows, slab_rows;
  int                   if_sh, in_sh, slab_sh;
  step  = conv_addr_pkg::addr_t'(cfg_stride) * conv_addr_pkg::addr_t'(krow);
  pad16 = conv_addr_pkg::addr_t'(cfg_pad);
  row   = ky + iy_start + step;
  ifm1  = cfg_if_start - 16'd1;
  r.valid       = (cfg_poy >= 16'd3) && (row >= pad16 + 16'd1) && (row <= pad16 + cfg_iy);
  r.word_sel    = ifm1[0];
  r.row_idx     = `CONV_ADDR_NONE;
  r.buf_adr     = `CONV_ADDR_NONE;
  r.slab_adr    = `CONV_ADDR_NONE;
  r.slab_wr_adr = `CONV_ADDR_NONE;
  r.buf_idx     = '0;
  r.slab_idx    = '0;
  r.slab_wr_idx = '0;
  if (r.valid) begin
    bias = ky + 16'd1 + step - pad16;
    base = cfg_base;
    // Top rows fall back into the previous group of three
    if (bias[15] || bias == 16'd0) begin
      bias = bias + 16'd3 * conv_addr_pkg::addr_t'(cfg_stride);
      base = cfg_base - 16'd1;
    end
    group = (bias - 16'd1) / 16'd3;
    case (cfg_stride)
      4'd1:    rib = base + group;
      4'd2:    rib = (base << 1) + group;
      default: rib = '0;
    endcase
    if_sh     = int'(cfg_nif) - `CONV_IFS_ROW_LOG2;
    in_sh     = if_sh + int'(cfg_ix) - `CONV_PIX_ROW_LOG2;
    slab_sh   = int'(cfg_nif) + int'(cfg_ix) - `CONV_PIX_ROW_LOG2;
    in_rows   = (16'd1 << (`CONV_IN_BUF_LOG2 - in_sh)) - 16'd1;
    slab_rows = (16'd1 << (`CONV_SLAB_BUF_LOG2 - slab_sh)) - 16'd1;
    r.row_idx = row;
    r.buf_idx = conv_addr_pkg::ring_idx_t'((bias - 16'd1) % 16'd3) + 2'd1;
    r.buf_adr = ((rib & in_rows) << in_sh)
              + ((cfg_row_start << if_sh) >> `CONV_PIX_ROW_LOG2)
              + (ifm1 >> `CONV_IFS_ROW_LOG2);
    r.slab_wr_adr = ((rib & slab_rows) << slab_sh)
                  + ((cfg_row_start << cfg_nif) >> `CONV_PIX_ROW_LOG2) + ifm1;
    r.slab_wr_idx = r.buf_idx;
    if (cfg_slab_num != 4'd0) begin
      r.slab_adr = ((rib & slab_rows) << slab_sh)
                 + ((cfg_slab_start << cfg_nif) >> `CONV_PIX_ROW_LOG2) + ifm1;
      r.slab_idx = r.buf_idx;
    end
  end
  return r;
endfunction

task automatic report_diff(input string name, input string field,
                           input logic [15:0] exp, input logic [15:0] act);
  $display("[FAIL] %s %s: expected %h actual %h", name, field, exp, act);
  abort_sim();
endtask

task automatic check_row(input string name, input logic exp_valid,
                         input conv_addr_pkg::addr_t exp_row, input logic act_valid,
                         input conv_addr_pkg::addr_t act_row);
  if (act_valid !== exp_valid) report_diff(name, "valid", 16'(exp_valid), 16'(act_valid));
  if (act_row !== exp_row) report_diff(name, "row_idx", exp_row, act_row);
endtask

task automatic check_buf(input string name, input conv_addr_pkg::addr_t exp_adr,
                         input conv_addr_pkg::ring_idx_t exp_idx, input logic exp_ws,
                         input conv_addr_pkg::addr_t act_adr,
                         input conv_addr_pkg::ring_idx_t act_idx, input logic act_ws);
  if (act_adr !== exp_adr) report_diff(name, "buf_adr", exp_adr, act_adr);
  if (act_idx !== exp_idx) report_diff(name, "buf_idx", 16'(exp_idx), 16'(act_idx));
  if (act_ws !== exp_ws) report_diff(name, "word_sel", 16'(exp_ws), 16'(act_ws));
endtask

task automatic check_slab(input string name, input conv_addr_pkg::addr_t exp_adr,
                          input conv_addr_pkg::ring_idx_t exp_idx,
                          input conv_addr_pkg::addr_t act_adr,
                          input conv_addr_pkg::ring_idx_t act_idx);
  if (act_adr !== exp_adr) report_diff(name, "slab_adr", exp_adr, act_adr);
  if (act_idx !== exp_idx) report_diff(name, "slab_idx", 16'(exp_idx), 16'(act_idx));
endtask

`endif

//--- tests/conv_addr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_addr_tb;

  localparam int N_RAND = 400;
  localparam int N_CMDS = N_RAND + 16;

  logic                     clk, arst_n, cmd_req, cmd_ack, res_req, res_ack;
  conv_addr_pkg::conv_op_e  cmd_op;
  conv_addr_pkg::addr_t     cmd_a, cmd_b, cmd_c;
  logic [1:0]               cmd_krow;
  logic                     res_valid, res_word_sel;
  conv_addr_pkg::addr_t     res_row_idx, res_buf_adr, res_slab_adr, res_slab_wr_adr;
  conv_addr_pkg::ring_idx_t res_buf_idx, res_slab_idx, res_slab_wr_idx;

  logic [31:0] lfsr_state;
  int          fetches_sent, results_seen;

  task automatic abort_sim();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  `include "conv_addr_model.svh"

  // Outstanding fetches, oldest first
  result_t    exp_q[$];
  string      name_q[$];
  logic [2:0] delay_q[$];

  conv_addr_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  function automatic conv_addr_pkg::addr_t rand_bits(input int n);
    conv_addr_pkg::addr_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Four-phase command, called just after a rising edge
  task automatic send_cmd(input conv_addr_pkg::conv_op_e op, input conv_addr_pkg::addr_t a,
                          input conv_addr_pkg::addr_t b, input conv_addr_pkg::addr_t c,
                          input logic [1:0] kr);
    int waits;
    cmd_op   = op;
    cmd_a    = a;
    cmd_b    = b;
    cmd_c    = c;
    cmd_krow = kr;
    cmd_req  = 1'b1;
    waits    = 0;
    do begin
      @(posedge clk);
      #1;
      waits++;
    end while (!cmd_ack);
    if (op != conv_addr_pkg::OP_FETCH && waits != 1) begin
      $display("Configuration command took %0d cycles to be acknowledged", waits);
      abort_sim();
    end
    if (op == conv_addr_pkg::OP_FETCH && res_req !== 1'b0) begin
      $display("res_req was already high in the cycle the fetch was acknowledged");
      abort_sim();
    end
    cmd_req = 1'b0;
    waits   = 0;
    do begin
      @(posedge clk);
      #1;
      waits++;
    end while (cmd_ack);
    if (waits != 1) begin
      $display("cmd_ack stayed high %0d cycles after cmd_req fell", waits);
      abort_sim();
    end
    if (op == conv_addr_pkg::OP_FETCH && res_req !== 1'b1) begin
      $display("res_req did not rise one cycle after the fetch was taken");
      abort_sim();
    end
  endtask

  task automatic set_shape(input conv_addr_pkg::field_t st, input conv_addr_pkg::field_t pd,
                           input conv_addr_pkg::field_t nif, input conv_addr_pkg::field_t ix,
                           input conv_addr_pkg::addr_t iy, input conv_addr_pkg::addr_t poy);
    cfg_stride = st;
    cfg_pad    = pd;
    cfg_nif    = nif;
    cfg_ix     = ix;
    cfg_iy     = iy;
    cfg_poy    = poy;
    send_cmd(conv_addr_pkg::OP_SET_SHAPE, {ix, nif, pd, st}, iy, poy, 2'd0);
  endtask

  task automatic set_base(input conv_addr_pkg::addr_t base, input conv_addr_pkg::addr_t rs,
                          input conv_addr_pkg::addr_t ifs);
    cfg_base      = base;
    cfg_row_start = rs;
    cfg_if_start  = ifs;
    send_cmd(conv_addr_pkg::OP_SET_BASE, base, rs, ifs, 2'd0);
  endtask

  task automatic set_slab(input conv_addr_pkg::field_t num, input conv_addr_pkg::addr_t ss);
    cfg_slab_num   = num;
    cfg_slab_start = ss;
    send_cmd(conv_addr_pkg::OP_SET_SLAB, {12'd0, num}, ss, 16'd0, 2'd0);
  endtask

  task automatic fetch_row(input string name, input conv_addr_pkg::addr_t ky,
                           input conv_addr_pkg::addr_t iy_start, input logic [1:0] krow,
                           input logic [2:0] delay);
    exp_q.push_back(predict(ky, iy_start, krow));
    name_q.push_back(name);
    delay_q.push_back(delay);
    fetches_sent++;
    send_cmd(conv_addr_pkg::OP_FETCH, ky, iy_start, 16'd0, krow);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result consumer

  initial begin : consumer
    result_t    exp;
    string      name;
    logic [2:0] delay;
    int         waits;
    wait (arst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      if (res_req) begin
        if (exp_q.size() == 0) begin
          $display("A result was offered with no fetch outstanding");
          abort_sim();
        end
        exp   = exp_q.pop_front();
        name  = name_q.pop_front();
        delay = delay_q.pop_front();
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        // Held data must still be the answer to this fetch
        check_row(name, exp.valid, exp.row_idx, res_valid, res_row_idx);
        check_buf(name, exp.buf_adr, exp.buf_idx, exp.word_sel,
                  res_buf_adr, res_buf_idx, res_word_sel);
        check_slab({name, " read"}, exp.slab_adr, exp.slab_idx, res_slab_adr, res_slab_idx);
        check_slab({name, " write"}, exp.slab_wr_adr, exp.slab_wr_idx,
                   res_slab_wr_adr, res_slab_wr_idx);
        res_ack = 1'b1;
        waits   = 0;
        do begin
          @(posedge clk);
          #1;
          waits++;
        end while (res_req);
        if (waits != 1) begin
          $display("res_req stayed high %0d cycles after res_ack rose", waits);
          abort_sim();
        end
        res_ack = 1'b0;
        results_seen++;
      end
    end
  end

  initial begin : watchdog
    repeat (N_CMDS * 100) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d results seen",
             N_CMDS * 100, results_seen, fetches_sent);
    abort_sim();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin : main
    conv_addr_pkg::field_t st, pd, nif, ix;
    conv_addr_pkg::addr_t  kind, v1, v2, v3;
    logic [1:0]            kr;
    logic [2:0]            dl;
    lfsr_state   = 32'h87c26830;
    fetches_sent = 0;
    results_seen = 0;
    arst_n   = 1'b0;
    cmd_req  = 1'b0;
    cmd_op   = conv_addr_pkg::OP_SET_SHAPE;
    cmd_a    = '0;
    cmd_b    = '0;
    cmd_c    = '0;
    cmd_krow = '0;
    res_ack  = 1'b0;
    {cfg_stride, cfg_pad, cfg_nif, cfg_ix, cfg_slab_num} = '0;
    {cfg_iy, cfg_poy, cfg_base, cfg_row_start, cfg_if_start, cfg_slab_start} = '0;
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    @(posedge clk);
    #1;
    if (cmd_ack !== 1'b0 || res_req !== 1'b0) begin
      $display("cmd_ack or res_req is not low after reset");
      abort_sim();
    end

    // Zero configuration and a layer of two output rows
    fetch_row("reset_poy", 16'd0, 16'd1, 2'd0, 3'd0);
    set_shape(4'd1, 4'd1, 4'd2, 4'd5, 16'd16, 16'd2);
    fetch_row("short_layer", 16'd1, 16'd3, 2'd1, 3'd2);

    // Padding rows, wrapped base and the bottom edge
    set_shape(4'd1, 4'd1, 4'd2, 4'd6, 16'd16, 16'd16);
    set_base(16'd5, 16'd64, 16'd3);
    set_slab(4'd2, 16'd32);
    fetch_row("pad_top", 16'd0, 16'd1, 2'd0, 3'd0);
    fetch_row("pad_wrap", 16'd0, 16'd2, 2'd0, 3'd1);
    fetch_row("bottom_edge", 16'd0, 16'd16, 2'd1, 3'd0);
    fetch_row("bottom_over", 16'd0, 16'd17, 2'd1, 3'd3);

    // Configuration lands while a result is held
    fetch_row("held", 16'd2, 16'd6, 2'd2, 3'd7);
    set_base(16'd9, 16'd128, 16'd8);
    set_slab(4'd0, 16'd0);
    fetch_row("after_cfg", 16'd2, 16'd6, 2'd2, 3'd1);

    for (int n = 0; n < N_RAND; n++) begin
      kind = rand_bits(3);
      if (kind == 16'd0) begin
        st = conv_addr_pkg::field_t'(rand_bits(1) + 16'd1);
        pd = conv_addr_pkg::field_t'(rand_bits(2) % 16'd3);
        nif = conv_addr_pkg::field_t'(rand_bits(2) + 16'd1);
        ix = conv_addr_pkg::field_t'(rand_bits(2) + 16'd5);
        v1 = rand_bits(6) + 16'd4;
        v2 = rand_bits(4);
        set_shape(st, pd, nif, ix, v1, v2);
      end else if (kind == 16'd1) begin
        v1 = rand_bits(8);
        v2 = rand_bits(10);
        v3 = rand_bits(6);
        set_base(v1, v2, v3);
      end else if (kind == 16'd2) begin
        st = conv_addr_pkg::field_t'(rand_bits(2));
        v1 = rand_bits(10);
        set_slab(st, v1);
      end else begin
        v1 = rand_bits(3);
        v2 = rand_bits(6);
        kr = 2'(rand_bits(2) % 16'd3);
        dl = 3'(rand_bits(3));
        fetch_row("random", v1, v2, kr, dl);
      end
    end

    while (results_seen < fetches_sent) @(posedge clk);
    repeat (20) @(posedge clk);
    #1;
    if (results_seen == fetches_sent && res_req === 1'b0 && exp_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Saw %0d results for %0d fetches", results_seen, fetches_sent);
      abort_sim();
    end
  end

endmodule

`default_nettype wire
